// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/controller.sv
      - logic/instr_decoder.sv
      - logic/datapath.sv
      - logic/ram.sv
      - logic/cpu_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/cpu_props.sv
      - sim/tb_cpu.sv

// ==== compile.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/controller.sv
logic/instr_decoder.sv
logic/datapath.sv
logic/ram.sv
logic/cpu_top.sv
sim/cpu_props.sv
sim/tb_cpu.sv

// ==== logic/controller.sv ====
`timescale 1ns/1ps

module controller (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::opcode_e  opcode,
    input  cpu_pkg::alu_op_e  alu_op,
    output cpu_pkg::ctrl_t    ctrl,
    output logic              halted
);

    // fdr is fetch with reset and fd is fetch and decode
    typedef enum logic [4:0] {
        fdr, fd, halt, stall1, stall2,
        mov_imm, mov_r1, mov_r2, mov_r3,
        mvn1, mvn2, mvn3,
        add1, add2, add3, add4,
        cmp1, cmp2, cmp3,
        and1, and2, and3, and4,
        ldr1, ldr2, ldr3, ldr4, ldr5
    } state_e;

    state_e state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fdr;
        end else begin
            case (state)
                fd: begin
                    case (opcode)
                        cpu_pkg::OP_ALU: begin
                            case (alu_op)
                                cpu_pkg::ALU_ADD: state <= add1;
                                cpu_pkg::ALU_CMP: state <= cmp1;
                                cpu_pkg::ALU_AND: state <= and1;
                                default:          state <= mvn1;
                            endcase
                        end
                        cpu_pkg::OP_MOV: begin
                            if (alu_op == cpu_pkg::ALU_AND)
                                state <= mov_imm;
                            else if (alu_op == cpu_pkg::ALU_ADD)
                                state <= mov_r1;
                            else
                                state <= fd;
                        end
                        cpu_pkg::OP_LDR: begin
                            if (alu_op == cpu_pkg::ALU_ADD)
                                state <= ldr1;
                            else
                                state <= fd;
                        end
                        cpu_pkg::OP_HALT: state <= halt;
                        default:          state <= fd;  // Unknown opcode spins here
                    endcase
                end
                fdr:     state <= stall1;
                mov_imm: state <= stall1;
                stall1:  state <= stall2;
                stall2:  state <= fd;
                mov_r1:  state <= mov_r2;
                mov_r2:  state <= mov_r3;
                add1:    state <= add2;
                add2:    state <= add3;
                add3:    state <= add4;
                cmp1:    state <= cmp2;
                cmp2:    state <= cmp3;
                and1:    state <= and2;
                and2:    state <= and3;
                and3:    state <= and4;
                mvn1:    state <= mvn2;
                mvn2:    state <= mvn3;
                ldr1:    state <= ldr2;
                ldr2:    state <= ldr3;
                ldr3:    state <= ldr4;
                ldr4:    state <= ldr5;
                ldr5:    state <= stall2;   // IR took the data word so refetch
                halt:    state <= halt;
                default: state <= fd;       // mov_r3, add4, cmp3, and4, mvn3
            endcase
        end
    end

    always_comb begin
        ctrl          = '0;
        ctrl.sel_addr = 1'b1;
        case (state)
            fdr: begin
                ctrl.load_ir  = 1'b1;
                ctrl.load_pc  = 1'b1;
                ctrl.clear_pc = 1'b1;
            end
            fd, stall1, stall2: ctrl.load_ir = 1'b1;
            mov_imm: begin
                ctrl.load_pc = 1'b1;
                ctrl.w_en    = 1'b1;
                ctrl.reg_sel = 2'b10;
                ctrl.wb_sel  = 2'b10;
                ctrl.load_ir = 1'b1;
            end
            mov_r1, mvn1: begin
                ctrl.load_pc = 1'b1;
                ctrl.en_b    = 1'b1;        // Rm
            end
            mov_r2, mvn2: begin
                ctrl.en_c  = 1'b1;
                ctrl.sel_a = 1'b1;
            end
            mov_r3, mvn3, add4, and4: begin
                ctrl.w_en    = 1'b1;
                ctrl.reg_sel = 2'b01;
                ctrl.load_ir = 1'b1;
            end
            add1, cmp1, and1, ldr1: begin
                ctrl.load_pc = 1'b1;
                ctrl.en_a    = 1'b1;
                ctrl.reg_sel = 2'b10;
            end
            add2, cmp2, and2: ctrl.en_b = 1'b1;
            add3, and3:       ctrl.en_c = 1'b1;
            cmp3: begin
                ctrl.en_status = 1'b1;
                ctrl.load_ir   = 1'b1;
            end
            ldr2: begin
                ctrl.en_c  = 1'b1;          // Rn + imm5
                ctrl.sel_b = 1'b1;
            end
            ldr3: ctrl.load_addr = 1'b1;
            ldr4: ctrl.sel_addr  = 1'b0;
            ldr5: begin
                ctrl.w_en    = 1'b1;
                ctrl.reg_sel = 2'b01;
                ctrl.wb_sel  = 2'b11;
                ctrl.load_ir = 1'b1;
            end
            default: ;                      // Halt keeps the defaults
        endcase
    end

    assign halted = (state == halt);

endmodule

// ==== logic/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define WORD_W 16                       // Data and instruction width
`define REG_COUNT 8                     // General registers
`define MEM_DEPTH 256                   // RAM words

`define ADDR_W $clog2(`MEM_DEPTH)
`define REG_IDX_W $clog2(`REG_COUNT)

`endif

// ==== logic/cpu_pkg.sv ====
`include "cpu_params.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        OP_LDR  = 3'b011,
        OP_ALU  = 3'b101,
        OP_MOV  = 3'b110,
        OP_HALT = 3'b111
    } opcode_e;

    // MOV reuses this field with 10 for immediate and 00 for register
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_CMP = 2'b01,
        ALU_AND = 2'b10,
        ALU_MVN = 2'b11
    } alu_op_e;

    typedef struct packed {
        opcode_e                opcode;
        alu_op_e                alu_op;
        logic [`REG_IDX_W-1:0]  rn;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`REG_IDX_W-1:0]  rm;
        logic [`WORD_W-1:0]     imm8;   // Sign-extended
        logic [`WORD_W-1:0]     imm5;   // Sign-extended
    } instr_t;

    typedef struct packed {
        logic       load_pc;
        logic       clear_pc;
        logic       load_ir;
        logic       load_addr;
        logic       sel_addr;           // 1 selects PC
        logic [1:0] reg_sel;            // 10 Rn, 01 Rd, 00 Rm
        logic [1:0] wb_sel;             // 00 C, 10 imm8, 11 memory
        logic       w_en;
        logic       en_a;
        logic       en_b;
        logic       en_c;
        logic       en_status;
        logic       sel_a;              // Zero into ALU A
        logic       sel_b;              // imm5 into ALU B
    } ctrl_t;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } status_t;

endpackage

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   prog_we,
    input  logic [`ADDR_W-1:0]     prog_addr,
    input  logic [`WORD_W-1:0]     prog_data,
    input  logic [`REG_IDX_W-1:0]  dbg_idx,
    output logic [`WORD_W-1:0]     dbg_data,
    output cpu_pkg::status_t       status,
    output logic                   halted
);

    cpu_pkg::ctrl_t      ctrl;
    cpu_pkg::instr_t     instr;
    logic [`ADDR_W-1:0]  pc;
    logic [`ADDR_W-1:0]  addr_reg;
    logic [`ADDR_W-1:0]  mem_addr;
    logic [`WORD_W-1:0]  ir;
    logic [`WORD_W-1:0]  mem_rdata;
    logic [`WORD_W-1:0]  c_out;
    logic                mem_we;

    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.clear_pc)
            pc <= '0;
        else if (ctrl.load_pc)
            pc <= pc + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            addr_reg <= '0;
        else if (ctrl.load_addr)
            addr_reg <= c_out[`ADDR_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_ir)
            ir <= mem_rdata;            // Word addressed one cycle earlier
    end

    // Program port owns the RAM while the core sits in reset
    always_comb begin
        if (!rst_n)
            mem_addr = prog_addr;
        else if (ctrl.sel_addr)
            mem_addr = pc;
        else
            mem_addr = addr_reg;
    end

    assign mem_we = prog_we && !rst_n;

    controller u_controller (
        .clk    (clk),
        .rst_n  (rst_n),
        .opcode (instr.opcode),
        .alu_op (instr.alu_op),
        .ctrl   (ctrl),
        .halted (halted)
    );

    instr_decoder u_decoder (
        .ir    (ir),
        .instr (instr)
    );

    datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .instr     (instr),
        .mem_rdata (mem_rdata),
        .c_out     (c_out),
        .status    (status),
        .dbg_idx   (dbg_idx),
        .dbg_data  (dbg_data)
    );

    ram u_ram (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (prog_data),
        .rdata (mem_rdata)
    );

endmodule

// ==== logic/datapath.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_pkg::ctrl_t         ctrl,
    input  cpu_pkg::instr_t        instr,
    input  logic [`WORD_W-1:0]     mem_rdata,
    output logic [`WORD_W-1:0]     c_out,
    output cpu_pkg::status_t       status,
    input  logic [`REG_IDX_W-1:0]  dbg_idx,
    output logic [`WORD_W-1:0]     dbg_data
);

    localparam int MSB = `WORD_W - 1;

    logic [`WORD_W-1:0]    regs [`REG_COUNT];
    logic [`REG_IDX_W-1:0] idx;
    logic [`WORD_W-1:0]    rd_data;
    logic [`WORD_W-1:0]    a, b, c;
    logic [`WORD_W-1:0]    alu_a, alu_b, alu_out, diff;
    logic [`WORD_W-1:0]    wb_data;

    always_comb begin
        case (ctrl.reg_sel)
            2'b10:   idx = instr.rn;
            2'b01:   idx = instr.rd;
            default: idx = instr.rm;
        endcase
    end

    assign rd_data = regs[idx];

    assign alu_a = ctrl.sel_a ? '0 : a;
    assign alu_b = ctrl.sel_b ? instr.imm5 : b;
    assign diff  = alu_a - alu_b;

    always_comb begin
        case (instr.alu_op)
            cpu_pkg::ALU_ADD: alu_out = alu_a + alu_b;   // Also MOV reg and LDR address
            cpu_pkg::ALU_CMP: alu_out = diff;
            cpu_pkg::ALU_AND: alu_out = alu_a & alu_b;
            default:          alu_out = ~alu_b;          // MVN
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            2'b10:   wb_data = instr.imm8;
            2'b11:   wb_data = mem_rdata;
            default: wb_data = c;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.w_en)
            regs[idx] <= wb_data;
        if (ctrl.en_a)
            a <= rd_data;
        if (ctrl.en_b)
            b <= rd_data;
        if (ctrl.en_c)
            c <= alu_out;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status <= '0;
        end else if (ctrl.en_status) begin
            status.z <= (diff == '0);
            status.n <= diff[MSB];
            // Operands of opposite sign and result sign differs from A
            status.v <= (alu_a[MSB] != alu_b[MSB]) && (diff[MSB] != alu_a[MSB]);
        end
    end

    assign c_out    = c;
    assign dbg_data = regs[dbg_idx];

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module instr_decoder (
    input  logic [`WORD_W-1:0] ir,
    output cpu_pkg::instr_t    instr
);

    always_comb begin
        instr.opcode = cpu_pkg::opcode_e'(ir[15:13]);
        instr.alu_op = cpu_pkg::alu_op_e'(ir[12:11]);
        instr.rn     = ir[10:8];
        instr.rd     = ir[7:5];
        instr.rm     = ir[2:0];                         // Shift in 4:3 ignored
        instr.imm8   = {{(`WORD_W - 8){ir[7]}}, ir[7:0]};
        instr.imm5   = {{(`WORD_W - 5){ir[4]}}, ir[4:0]};
    end

endmodule

// ==== logic/ram.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module ram (
    input  logic                clk,
    input  logic                we,
    input  logic [`ADDR_W-1:0]  addr,
    input  logic [`WORD_W-1:0]  wdata,
    output logic [`WORD_W-1:0]  rdata
);

    logic [`WORD_W-1:0] mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];             // Old data on a write
    end

endmodule

// ==== sim/cpu_props.sv ====
`timescale 1ns/1ps

module cpu_props (
    input logic           clk,
    input logic           rst_n,
    input logic           halted,
    input cpu_pkg::ctrl_t ctrl
);

    int fail_count = 0;

    halt_clear_on_reset: assert property (@(posedge clk) !rst_n |=> !halted)
        else begin
            $error("halted high after a reset cycle");
            fail_count++;
        end

    // Only a reset may bring the core out of halt
    halt_sticky: assert property (@(posedge clk) (halted && rst_n) |=> (halted || !rst_n))
        else begin
            $error("halted fell without reset");
            fail_count++;
        end

    addr_then_mem: assert property (@(posedge clk) disable iff (!rst_n)
                                    ctrl.load_addr |=> !ctrl.sel_addr)
        else begin
            $error("load_addr not followed by data address select");
            fail_count++;
        end

    no_wen_with_flags: assert property (@(posedge clk) disable iff (!rst_n)
                                        !(ctrl.w_en && ctrl.en_status))
        else begin
            $error("w_en and en_status in one cycle");
            fail_count++;
        end

endmodule

bind cpu_top cpu_props u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .halted (halted),
    .ctrl   (ctrl)
);

// ==== sim/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu;

    localparam logic [15:0] HALT_W       = 16'hE000;
    localparam logic [7:0]  DATA_ADDR    = 8'd200;
    localparam int          RESET_CYCLES = 16;

    typedef struct packed {
        logic [7:0][15:0] prog;
        logic [15:0]      data;         // Word at DATA_ADDR
        logic [2:0]       chk_reg;
        logic [15:0]      exp_val;
        logic [2:0]       exp_flags;    // z n v
    } test_t;

    logic                  clk;
    logic                  rst_n;
    logic                  prog_we;
    logic [`ADDR_W-1:0]    prog_addr;
    logic [`WORD_W-1:0]    prog_data;
    logic [`REG_IDX_W-1:0] dbg_idx;
    logic [`WORD_W-1:0]    dbg_data;
    cpu_pkg::status_t      status;
    logic                  halted;

    test_t       tests[$];
    logic [31:0] rng;
    int          cycles = 0;
    int          limit = 0;
    int          errors = 0;
    int          failed_cases = 0;

    cpu_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .dbg_idx   (dbg_idx),
        .dbg_data  (dbg_data),
        .status    (status),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] sext8(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    function automatic logic [15:0] movi(input logic [2:0] rn, input logic [7:0] imm);
        return {3'b110, 2'b10, rn, imm};
    endfunction

    function automatic logic [15:0] movr(input logic [2:0] rd, input logic [2:0] rm);
        return {3'b110, 2'b00, 3'b000, rd, 2'b00, rm};
    endfunction

    // op is 00 ADD, 01 CMP, 10 AND, 11 MVN
    function automatic logic [15:0] alu_instr(input logic [1:0] op,
                                              input logic [2:0] rn, rd, rm);
        return {3'b101, op, rn, rd, 2'b00, rm};
    endfunction

    function automatic logic [15:0] ldr_instr(input logic [2:0] rd, rn,
                                              input logic [4:0] off);
        return {3'b011, 2'b00, rn, rd, off};
    endfunction

    // Overflow when the true signed difference leaves the 16-bit range
    function automatic logic [2:0] cmp_flags(input logic [15:0] a, b);
        int          diff;
        logic [15:0] d;
        diff = $signed(a) - $signed(b);
        d    = a - b;
        return {d == 16'h0, d[15], (diff > 32767) || (diff < -32768)};
    endfunction

    task automatic add_test(input logic [15:0] w0, w1, w2, w3, w4, data,
                            input logic [2:0] chk_reg, input logic [15:0] exp_val,
                            input logic [2:0] exp_flags);
        test_t t;
        t.prog      = {8{HALT_W}};
        t.prog[0]   = w0;
        t.prog[1]   = w1;
        t.prog[2]   = w2;
        t.prog[3]   = w3;
        t.prog[4]   = w4;
        t.data      = data;
        t.chk_reg   = chk_reg;
        t.exp_val   = exp_val;
        t.exp_flags = exp_flags;
        tests.push_back(t);
    endtask

    task automatic build_table();
        logic [15:0] a;
        logic [7:0]  b8;
        add_test(movi(1, 8'h35), HALT_W, HALT_W, HALT_W, HALT_W, 16'h0, 1, 16'h0035, 3'b000);
        add_test(movi(6, 8'h80), HALT_W, HALT_W, HALT_W, HALT_W, 16'h0, 6, 16'hFF80, 3'b000);
        add_test(movi(2, 8'h9C), movr(5, 2), HALT_W, HALT_W, HALT_W, 16'h0, 5,
                 sext8(8'h9C), 3'b000);
        add_test(movi(3, 8'h5A), alu_instr(2'b11, 0, 6, 3), HALT_W, HALT_W, HALT_W, 16'h0, 6,
                 ~sext8(8'h5A), 3'b000);
        // CMP names the checked register as Rd so a stray write shows
        add_test(movi(1, 8'h40), movi(2, 8'h40), alu_instr(2'b01, 1, 1, 2), HALT_W, HALT_W,
                 16'h0, 1, 16'h0040, cmp_flags(16'h0040, 16'h0040));
        add_test(movi(1, 8'h10), movi(2, 8'h20), alu_instr(2'b01, 1, 2, 2), HALT_W, HALT_W,
                 16'h0, 2, 16'h0020, cmp_flags(16'h0010, 16'h0020));
        add_test(movi(1, 8'hC8), ldr_instr(2, 1, 5'd0), movi(3, 8'hFF),
                 alu_instr(2'b01, 2, 2, 3), HALT_W, 16'h7FFF, 2, 16'h7FFF,
                 cmp_flags(16'h7FFF, 16'hFFFF));
        // Base 0xFFC3 plus 5 and base 0xFFCC minus 4 both land on address 200
        add_test(movi(1, 8'hC3), ldr_instr(4, 1, 5'd5), HALT_W, HALT_W, HALT_W, 16'hBEEF, 4,
                 16'hBEEF, 3'b000);
        add_test(movi(1, 8'hCC), ldr_instr(7, 1, 5'h1C), HALT_W, HALT_W, HALT_W, 16'h1234, 7,
                 16'h1234, 3'b000);
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            a   = rng[15:0];
            rng = xorshift(rng);
            b8  = rng[7:0];
            add_test(movi(1, 8'hC8), ldr_instr(2, 1, 5'd0), movi(3, b8),
                     alu_instr((i % 2 == 0) ? 2'b00 : 2'b10, 2, 4, 3), HALT_W, a, 4,
                     (i % 2 == 0) ? a + sext8(b8) : a & sext8(b8), 3'b000);
        end
    endtask

    task automatic run_test(input int n);
        test_t t;
        int    errs_before;
        t           = tests[n];
        errs_before = errors;
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            prog_we   = (i <= 8);
            prog_addr = (i < 8) ? i : DATA_ADDR;
            prog_data = (i < 8) ? t.prog[i] : t.data;
            @(posedge clk);
            #2;
        end
        prog_we = 1'b0;
        assert (!halted && status == 3'b000) else begin
            $display("ERR %0t: case %0d halted is %b and flags are %b after reset",
                     $time, n, halted, status);
            errors++;
        end
        rst_n = 1'b1;
        do @(negedge clk); while (!halted);
        repeat (3) @(negedge clk);
        assert (halted) else begin
            $display("ERR %0t: case %0d halted dropped after the halt state", $time, n);
            errors++;
        end
        @(posedge clk);
        #2;
        dbg_idx = t.chk_reg;
        @(negedge clk);
        assert (dbg_data == t.exp_val) else begin
            $display("ERR %0t: case %0d r%0d is %h, expected %h",
                     $time, n, t.chk_reg, dbg_data, t.exp_val);
            errors++;
        end
        assert (status == t.exp_flags) else begin
            $display("ERR %0t: case %0d flags are %b, expected %b",
                     $time, n, status, t.exp_flags);
            errors++;
        end
        if (errors != errs_before)
            failed_cases++;
        $display("case %0d r%0d=%h flags=%b %s", n, t.chk_reg, dbg_data, status,
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_idx   = '0;
        rng       = 32'd88;
        build_table();
        limit = (tests.size() * 8 * 8 + RESET_CYCLES * tests.size()) * 2;
        foreach (tests[n])
            run_test(n);
        errors = errors + uut.u_props.fail_count;   // Bound property failures
        $display("%0d cases run, %0d failed, %0d errors", tests.size(), failed_cases, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    initial begin
        wait (limit > 0);
        while (cycles < limit)
            @(posedge clk);
        $display("Processor never reached halt within %0d cycles", limit);
        $display("test failed");
        $finish;
    end

endmodule
